//--- sources.f
hdl/rv_pkg.sv
hdl/core_if.sv
hdl/inst_fetch.sv
hdl/ctrl.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/retire_unit.sv
hdl/rv_core.sv
dv/tb_mem_model.sv
dv/tb_rv_core.sv

//--- dv/tb_rv_core.sv
module tb_rv_core import rv_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_INSTS    = 28; // retires over both programs
    localparam int MAX_CYCLES = N_INSTS * 6 + 50;

    logic                  clk;
    logic                  arst_n;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic [XLEN-1:0]       wb_adr;
    logic [ILEN-1:0]       wb_rdata;
    logic                  wb_ack;
    logic                  retire_valid;
    logic [XLEN-1:0]       retire_pc;
    logic [ILEN-1:0]       retire_inst;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic                  retire_wen;
    logic [XLEN-1:0]       retire_data;
    logic                  halted;
    halt_e                 halt_cause;
    logic [ILEN-1:0]       bad_inst;

    logic [31:0] image [256]; // program as the reference model sees it
    int          load_idx;
    logic [63:0] m_regs [32];
    logic [63:0] m_pc;
    logic [63:0] m_next_pc;
    logic [31:0] exp_inst;
    logic [31:0] exp_bad;
    logic        exp_wen;
    logic [4:0]  exp_rd;
    logic [63:0] exp_data;
    halt_e       exp_halt;
    int          retired = 0;
    int          errors = 0;
    int          bus_errors = 0;
    int          mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles;

    rv_core u_rv_core (
        .clk          (clk),
        .arst_n       (arst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_rdata     (wb_rdata),
        .wb_ack       (wb_ack),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .retire_rd    (retire_rd),
        .retire_wen   (retire_wen),
        .retire_data  (retire_data),
        .halted       (halted),
        .halt_cause   (halt_cause),
        .bad_inst     (bad_inst)
    );

    tb_mem_model #(.SEED(32'h6dac_7898)) u_mem (
        .clk    (clk),
        .arst_n (arst_n),
        .cyc    (wb_cyc),
        .stb    (wb_stb),
        .adr    (wb_adr),
        .rdata  (wb_rdata),
        .ack    (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, 3'b000, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input int imm);
        return {imm[11:0], rs1, 3'b000, rd, op};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_bne(input logic [4:0] rs1, input logic [4:0] rs2,
                                            input int imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic fill_image();
        logic [63:0] addr;

        for (int i = 0; i < 256; i++) begin
            addr         = RESET_PC + 64'(i * 4);
            image[i]     = addr[31:0] ^ addr[63:32]; // low bits 00 decode as illegal
            u_mem.rom[i] = image[i];
        end
        load_idx = 0;
    endtask

    task automatic put(input logic [31:0] w);
        image[load_idx]     = w;
        u_mem.rom[load_idx] = w;
        load_idx++;
    endtask

    // expected record from the ISA rules of the supported subset
    task automatic predict();
        logic [31:0] inst;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_i;
        logic [63:0] imm_b;
        logic [63:0] imm_j;
        logic [63:0] imm_u;

        inst  = image[(m_pc - RESET_PC) >> 2];
        a     = m_regs[inst[19:15]];
        b     = m_regs[inst[24:20]];
        imm_i = {{52{inst[31]}}, inst[31:20]};
        imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
        exp_inst  = inst;
        exp_rd    = inst[11:7];
        exp_wen   = 1'b1;
        exp_data  = '0;
        exp_halt  = HALT_NONE;
        m_next_pc = m_pc + 4;
        case (inst[6:0])
            7'h33: begin
                if (inst[14:12] == 3'd0 && inst[31:25] == 7'h00) exp_data = a + b;
                else if (inst[14:12] == 3'd0 && inst[31:25] == 7'h20) exp_data = a - b;
                else exp_halt = HALT_ILLEGAL;
            end
            7'h13: begin
                if (inst[14:12] == 3'd0) exp_data = a + imm_i;
                else exp_halt = HALT_ILLEGAL;
            end
            7'h63: begin
                exp_wen = 1'b0;
                if (inst[14:12] != 3'd1) exp_halt = HALT_ILLEGAL;
                else if (a != b) m_next_pc = m_pc + imm_b;
            end
            7'h6f: begin
                exp_data  = m_pc + 4;
                m_next_pc = m_pc + imm_j;
            end
            7'h67: begin
                exp_data  = m_pc + 4;
                m_next_pc = (a + imm_i) & ~64'h1;
                if (inst[14:12] != 3'd0) exp_halt = HALT_ILLEGAL;
            end
            7'h37: exp_data = imm_u;
            7'h17: exp_data = m_pc + imm_u;
            7'h73: exp_halt = (inst == 32'h0010_0073) ? HALT_EBREAK : HALT_ILLEGAL;
            default: exp_halt = HALT_ILLEGAL;
        endcase
        if (exp_halt != HALT_NONE) exp_wen = 1'b0;
        exp_bad = (exp_halt == HALT_ILLEGAL) ? inst : '0;
    endtask

    // reference model steps once per retire record
    always @(posedge clk) begin
        if (!arst_n) begin
            m_pc = RESET_PC;
            for (int i = 0; i < 32; i++) begin
                m_regs[i] = '0;
            end
            predict();
        end else if (retire_valid) begin
            retired++;
            if (exp_halt == HALT_NONE) begin
                if (exp_wen && exp_rd != 0) m_regs[exp_rd] = exp_data;
                m_pc = m_next_pc;
                predict();
            end
        end
    end

    task automatic value_fail(input string sig, input logic [63:0] got,
                              input logic [63:0] want, input bit on_bus);
        if (on_bus) bus_errors++;
        else errors++;
        $display("FAILED %s: got %h, expected %h", sig, got, want);
    endtask

    task automatic plain_fail(input string msg, input bit on_bus);
        if (on_bus) bus_errors++;
        else errors++;
        $display("error: %s", msg);
    endtask

    chk_pc: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid |-> retire_pc == m_pc)
        else value_fail("retire_pc", $sampled(retire_pc), $sampled(m_pc), 1'b0);
    chk_inst: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid |-> retire_inst == exp_inst)
        else value_fail("retire_inst", $sampled(retire_inst), $sampled(exp_inst), 1'b0);
    chk_wen: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid |-> retire_wen == exp_wen)
        else value_fail("retire_wen", $sampled(retire_wen), $sampled(exp_wen), 1'b0);
    chk_rd: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid && exp_wen |-> retire_rd == exp_rd)
        else value_fail("retire_rd", $sampled(retire_rd), $sampled(exp_rd), 1'b0);
    chk_data: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid && exp_wen |-> retire_data == exp_data)
        else value_fail("retire_data", $sampled(retire_data), $sampled(exp_data), 1'b0);
    chk_halted: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid |-> halted == (exp_halt != HALT_NONE))
        else plain_fail("halted does not match the retiring instruction", 1'b0);
    chk_cause: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid && exp_halt != HALT_NONE |-> halt_cause == exp_halt)
        else value_fail("halt_cause", $sampled(halt_cause), $sampled(exp_halt), 1'b0);
    chk_bad: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid && exp_halt != HALT_NONE |-> bad_inst == exp_bad)
        else value_fail("bad_inst", $sampled(bad_inst), $sampled(exp_bad), 1'b0);
    chk_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        halted |-> !wb_cyc)
        else plain_fail("bus request after the core halted", 1'b0);

    // wishbone classic handshake
    chk_hold: assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
        else plain_fail("request dropped or address moved before ack", 1'b1);
    chk_adr: assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb |-> wb_adr == m_pc)
        else value_fail("wb_adr", $sampled(wb_adr), $sampled(m_pc), 1'b1);
    chk_close: assert property (@(posedge clk) disable iff (!arst_n)
        wb_ack |=> !wb_cyc)
        else plain_fail("cycle still open after ack", 1'b1);
    chk_pair: assert property (@(posedge clk) disable iff (!arst_n)
        wb_cyc == wb_stb)
        else plain_fail("wb_cyc and wb_stb disagree", 1'b1);

    task automatic wait_retired(input int n);
        while (retired < n) begin
            @(negedge clk);
        end
    endtask

    task automatic report(input string name, input bit on_bus);
        int n;

        n = on_bus ? bus_errors : errors - mark;
        if (!on_bus) mark = errors;
        tests_run++;
        if (n != 0) tests_failed++;
        $display("%-14s %s (%0d errors)", name, (n == 0) ? "ok" : "failed", n);
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        fill_image();
        put(enc_i(7'h13, 1, 0, -5));         // addi x1, x0, -5
        put(enc_i(7'h13, 2, 0, 100));        // addi x2, x0, 100
        put(enc_r(7'h00, 3, 1, 2));          // add x3, x1, x2 wraps
        put(enc_r(7'h20, 4, 1, 2));          // sub x4, x1, x2
        put(enc_i(7'h13, 0, 2, 7));          // addi x0, x2, 7
        put(enc_r(7'h00, 6, 0, 2));          // add x6, x0, x2
        put(enc_r(7'h20, 7, 0, 1));          // sub x7, x0, x1
        put(enc_u(7'h37, 8, 20'h80000));     // negative lui
        put(enc_u(7'h37, 9, 20'h12345));
        put(enc_u(7'h17, 10, 20'hfffff));    // auipc to pc - 4096
        put(enc_u(7'h17, 11, 20'h00001));
        put(enc_bne(1, 2, 8));               // taken
        put(enc_i(7'h13, 12, 0, 1));         // skipped
        put(enc_bne(6, 2, 8));               // not taken
        put(enc_i(7'h13, 13, 0, 2));
        put(enc_i(7'h13, 14, 0, 3));         // loop count
        put(enc_i(7'h13, 14, 14, -1));
        put(enc_bne(14, 0, -4));             // backward branch taken twice
        put(enc_jal(15, 12));
        put(enc_i(7'h13, 16, 0, 9));         // skipped
        put(enc_i(7'h13, 16, 0, 9));         // skipped
        put(enc_u(7'h17, 17, 20'h0));        // auipc x17, 0
        put(enc_i(7'h67, 18, 17, 13));       // jalr to an odd target
        put(enc_i(7'h13, 19, 0, 7));         // skipped
        put(enc_jal(0, 8));                  // link into x0
        put(enc_i(7'h13, 19, 0, 7));         // skipped
        put(32'h0010_0073);                  // ebreak
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        wait_retired(7);
        report("arithmetic", 1'b0);
        wait_retired(11);
        report("upper_imm", 1'b0);
        wait_retired(21);
        report("branches", 1'b0);
        wait_retired(25);
        report("jumps", 1'b0);
        wait_retired(26);
        repeat (8) @(negedge clk); // room for a stray request
        report("ebreak_halt", 1'b0);
        report("bus_protocol", 1'b1);

        @(posedge clk);
        arst_n <= 1'b0;
        fill_image();
        put(enc_i(7'h13, 1, 0, 1));          // addi x1, x0, 1
        put(32'h0010_3423);                  // sd x1, 8(x0)
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        wait_retired(28);
        repeat (4) @(negedge clk);
        report("illegal_halt", 1'b0);

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors + bus_errors);
        if (tests_failed == 0 && errors + bus_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- dv/tb_mem_model.sv
module tb_mem_model #(
    parameter int unsigned SEED  = 32'h6dac_7898,
    parameter int          DEPTH = 256,
    parameter logic [63:0] BASE  = 64'h8000_0000
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cyc,
    input  logic        stb,
    input  logic [63:0] adr,
    output logic [31:0] rdata,
    output logic        ack
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_TAB = 1024;

    logic [31:0] rom [DEPTH];          // written by the test
    int unsigned wait_tab [WAIT_TAB];  // wait states per request, 0 to 3
    int unsigned req_cnt = 0;
    int unsigned waited;
    logic [63:0] offset;

    initial begin
        void'($urandom(SEED));
        for (int i = 0; i < WAIT_TAB; i++) begin
            wait_tab[i] = $urandom % 4;
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            waited <= 0;
        end else if (cyc && stb) begin
            if (ack) begin
                waited  <= 0;
                req_cnt <= req_cnt + 1; // next request draws a new wait count
            end else begin
                waited <= waited + 1;
            end
        end
    end

    assign offset = adr - BASE;
    assign ack    = cyc && stb && (waited == wait_tab[req_cnt % WAIT_TAB]);
    assign rdata  = (offset < DEPTH * 4) ? rom[offset >> 2] : 32'h0; // unmapped reads as zero

endmodule

//--- hdl/rv_core.sv
module rv_core import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic [XLEN-1:0]       wb_adr,
    input  logic [ILEN-1:0]       wb_rdata,
    input  logic                  wb_ack,
    output logic                  retire_valid,
    output logic [XLEN-1:0]       retire_pc,
    output logic [ILEN-1:0]       retire_inst,
    output logic [REG_ADDR_W-1:0] retire_rd,
    output logic                  retire_wen,
    output logic [XLEN-1:0]       retire_data,
    output logic                  halted,
    output halt_e                 halt_cause,
    output logic [ILEN-1:0]       bad_inst
);

    logic [XLEN-1:0]       pc;
    logic [ILEN-1:0]       inst;
    logic                  exec_valid;
    logic [XLEN-1:0]       next_pc;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic [ILEN-1:0]       dec_bad_inst; // from decoder, not yet latched

    dec_if    u_dec_if ();
    retire_if u_retire_if ();

    inst_fetch u_inst_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .wb_rdata   (wb_rdata),
        .wb_ack     (wb_ack),
        .next_pc    (next_pc),
        .halted     (halted),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .pc         (pc),
        .inst       (inst),
        .exec_valid (exec_valid)
    );

    ctrl u_ctrl (
        .inst     (inst),
        .dec      (u_dec_if.dec),
        .bad_inst (dec_bad_inst)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    exec_unit u_exec_unit (
        .pc         (pc),
        .inst       (inst),
        .exec_valid (exec_valid),
        .dec        (u_dec_if.exe),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .next_pc    (next_pc),
        .ret        (u_retire_if.exe)
    );

    retire_unit u_retire_unit (
        .clk          (clk),
        .arst_n       (arst_n),
        .ret          (u_retire_if.ret),
        .bad_inst_in  (dec_bad_inst),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .retire_rd    (retire_rd),
        .retire_wen   (retire_wen),
        .retire_data  (retire_data),
        .halted       (halted),
        .halt_cause   (halt_cause),
        .bad_inst     (bad_inst)
    );

endmodule

//--- hdl/retire_unit.sv
module retire_unit import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    retire_if.ret                 ret,
    input  logic [ILEN-1:0]       bad_inst_in,
    output logic                  rf_we,
    output logic [REG_ADDR_W-1:0] rf_waddr,
    output logic [XLEN-1:0]       rf_wdata,
    output logic                  retire_valid,
    output logic [XLEN-1:0]       retire_pc,
    output logic [ILEN-1:0]       retire_inst,
    output logic [REG_ADDR_W-1:0] retire_rd,
    output logic                  retire_wen,
    output logic [XLEN-1:0]       retire_data,
    output logic                  halted,
    output halt_e                 halt_cause,
    output logic [ILEN-1:0]       bad_inst
);

    logic halt_now;

    assign halt_now = ret.valid && (ret.halt_req != HALT_NONE);
    assign rf_we    = ret.valid && ret.wen && (ret.halt_req == HALT_NONE);
    assign rf_waddr = ret.rd;
    assign rf_wdata = ret.wdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid <= 1'b0;
            halted       <= 1'b0;
            halt_cause   <= HALT_NONE;
            bad_inst     <= '0;
        end else begin
            retire_valid <= ret.valid; // one pulse per execute cycle
            if (halt_now && !halted) begin
                halted     <= 1'b1;
                halt_cause <= ret.halt_req;
                bad_inst   <= bad_inst_in; // zero for ebreak
            end
        end
    end

    // trace record
    always_ff @(posedge clk) begin
        if (ret.valid) begin
            retire_pc   <= ret.pc;
            retire_inst <= ret.inst;
            retire_rd   <= ret.rd;
            retire_wen  <= rf_we;
            retire_data <= ret.wdata;
        end
    end

endmodule

//--- hdl/exec_unit.sv
module exec_unit import rv_pkg::*; (
    input  logic [XLEN-1:0]       pc,
    input  logic [ILEN-1:0]       inst,
    input  logic                  exec_valid,
    dec_if.exe                    dec,
    input  logic [XLEN-1:0]       rs1_data,
    input  logic [XLEN-1:0]       rs2_data,
    output logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]       next_pc,
    retire_if.exe                 ret
);

    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic            taken;

    assign rs1_addr = dec.rs1;
    assign rs2_addr = dec.rs2;

    // sign extended immediates
    always_comb begin
        case (dec.imm_op)
            IMM_I:   imm = {{(XLEN-12){inst[31]}}, inst[31:20]};
            IMM_B:   imm = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                            inst[11:8], 1'b0};
            IMM_J:   imm = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                            inst[30:21], 1'b0};
            default: imm = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
        endcase
    end

    always_comb begin
        case (dec.alu_src)
            SRC_REG:     begin op_a = rs1_data; op_b = rs2_data; end
            SRC_IMM:     begin op_a = rs1_data; op_b = imm;      end
            SRC_IMM_PC:  begin op_a = pc;       op_b = imm;      end
            default:     begin op_a = pc;       op_b = XLEN'(4); end
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            default: alu_res = op_a & op_b;
        endcase
    end

    assign taken = dec.branch && (alu_res != '0); // bne

    always_comb begin
        if (taken || (dec.jump && !dec.jalr)) begin
            next_pc = pc + imm;
        end else if (dec.jalr) begin
            next_pc = (rs1_data + imm) & ~XLEN'(1);
        end else begin
            next_pc = pc + XLEN'(4);
        end
    end

    assign ret.valid    = exec_valid;
    assign ret.pc       = pc;
    assign ret.inst     = inst;
    assign ret.wen      = dec.reg_wen;
    assign ret.rd       = dec.rd;
    assign ret.wdata    = alu_res;
    assign ret.halt_req = dec.halt_req;

endmodule

//--- hdl/reg_file.sv
module reg_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin // x0 never written
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

//--- hdl/ctrl.sv
module ctrl import rv_pkg::*; (
    input  logic [ILEN-1:0] inst,
    dec_if.dec              dec,
    output logic [ILEN-1:0] bad_inst
);

    logic [OPCODE_W-1:0]   opcode;
    logic [FUNCT3_W-1:0]   funct3;
    logic [FUNCT7_W-1:0]   funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;

    assign opcode = inst[OPCODE_W-1:0];
    assign funct3 = inst[FUNCT3_BASE +: FUNCT3_W];
    assign funct7 = inst[FUNCT7_BASE +: FUNCT7_W];
    assign rd     = inst[RD_BASE +: REG_ADDR_W];
    assign rs1    = inst[RS1_BASE +: REG_ADDR_W];
    assign rs2    = inst[RS2_BASE +: REG_ADDR_W];

    always_comb begin
        logic illegal;

        illegal      = 1'b0;
        dec.reg_wen  = 1'b0;
        dec.rd       = '0;
        dec.rs1      = '0;
        dec.rs2      = '0;
        dec.imm_op   = IMM_I;
        dec.alu_op   = ALU_AND; // harmless default
        dec.alu_src  = SRC_REG;
        dec.branch   = 1'b0;
        dec.jump     = 1'b0;
        dec.jalr     = 1'b0;
        dec.halt_req = HALT_NONE;
        bad_inst     = '0;

        case (opcode)
            OP_R: begin
                dec.reg_wen = 1'b1;
                dec.rd      = rd;
                dec.rs1     = rs1;
                dec.rs2     = rs2;
                if (funct3 == FUNCT3_ADD_SUB && funct7 == FUNCT7_ADD) begin
                    dec.alu_op = ALU_ADD;
                end else if (funct3 == FUNCT3_ADD_SUB && funct7 == FUNCT7_SUB) begin
                    dec.alu_op = ALU_SUB;
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_IMM: begin
                dec.reg_wen = 1'b1;
                dec.rd      = rd;
                dec.rs1     = rs1;
                dec.alu_op  = ALU_ADD;
                dec.alu_src = SRC_IMM;
                illegal     = (funct3 != FUNCT3_ADDI); // only addi
            end
            OP_BRANCH: begin
                dec.rs1    = rs1;
                dec.rs2    = rs2;
                dec.imm_op = IMM_B;
                dec.alu_op = ALU_SUB; // nonzero difference means taken
                dec.branch = 1'b1;
                illegal    = (funct3 != FUNCT3_BNE);
            end
            OP_JAL: begin
                dec.reg_wen = 1'b1;
                dec.rd      = rd;
                dec.imm_op  = IMM_J;
                dec.alu_op  = ALU_ADD;
                dec.alu_src = SRC_FOUR_PC; // link value
                dec.jump    = 1'b1;
            end
            OP_JALR: begin
                dec.reg_wen = 1'b1;
                dec.rd      = rd;
                dec.rs1     = rs1;
                dec.imm_op  = IMM_I;
                dec.alu_op  = ALU_ADD;
                dec.alu_src = SRC_FOUR_PC;
                dec.jump    = 1'b1;
                dec.jalr    = 1'b1;
                illegal     = (funct3 != FUNCT3_JALR);
            end
            OP_LUI: begin
                dec.reg_wen = 1'b1;
                dec.rd      = rd; // rs1 stays x0
                dec.imm_op  = IMM_U;
                dec.alu_op  = ALU_ADD;
                dec.alu_src = SRC_IMM;
            end
            OP_AUIPC: begin
                dec.reg_wen = 1'b1;
                dec.rd      = rd;
                dec.imm_op  = IMM_U;
                dec.alu_op  = ALU_ADD;
                dec.alu_src = SRC_IMM_PC;
            end
            OP_SYSTEM: begin
                if (inst == EBREAK_INST) begin
                    dec.halt_req = HALT_EBREAK;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: begin
                illegal = 1'b1;
            end
        endcase

        if (illegal) begin
            dec.reg_wen  = 1'b0;
            dec.halt_req = HALT_ILLEGAL;
            bad_inst     = inst;
        end
    end

endmodule

//--- hdl/inst_fetch.sv
module inst_fetch import rv_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [ILEN-1:0] wb_rdata,
    input  logic            wb_ack,
    input  logic [XLEN-1:0] next_pc,
    input  logic            halted,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic [XLEN-1:0] wb_adr,
    output logic [XLEN-1:0] pc,
    output logic [ILEN-1:0] inst,
    output logic            exec_valid
);

    fetch_state_e state;
    logic         req; // wishbone cycle open

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_FETCH;
            req   <= 1'b0;
            pc    <= RESET_PC;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (req) begin
                        if (wb_ack) begin // ack ends the cycle
                            req   <= 1'b0;
                            state <= ST_EXEC;
                        end
                    end else if (halted) begin
                        state <= ST_HALT; // last retire was ebreak or illegal
                    end else begin
                        req <= 1'b1;
                    end
                end
                ST_EXEC: begin
                    pc    <= next_pc;
                    state <= ST_FETCH;
                end
                default: begin
                    state <= ST_HALT; // only reset leaves
                end
            endcase
        end
    end

    // instruction register, loaded on the ack edge
    always_ff @(posedge clk) begin
        if (state == ST_FETCH && req && wb_ack) begin
            inst <= wb_rdata;
        end
    end

    assign wb_cyc     = req;
    assign wb_stb     = req;
    assign wb_adr     = pc; // stable while the cycle is open
    assign exec_valid = (state == ST_EXEC);

endmodule

//--- hdl/core_if.sv
interface dec_if import rv_pkg::*; ();
    logic                  reg_wen;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    imm_op_e               imm_op;
    alu_op_e               alu_op;
    alu_src_e              alu_src;
    logic                  branch;
    logic                  jump;
    logic                  jalr;
    halt_e                 halt_req;

    modport dec (output reg_wen, rd, rs1, rs2, imm_op, alu_op, alu_src,
                 branch, jump, jalr, halt_req);
    modport exe (input reg_wen, rd, rs1, rs2, imm_op, alu_op, alu_src,
                 branch, jump, jalr, halt_req);
endinterface

interface retire_if import rv_pkg::*; ();
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [ILEN-1:0]       inst;
    logic                  wen;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       wdata;
    halt_e                 halt_req;

    modport exe (output valid, pc, inst, wen, rd, wdata, halt_req);
    modport ret (input valid, pc, inst, wen, rd, wdata, halt_req);
endinterface

//--- hdl/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC    = 64'h8000_0000;
    localparam logic [ILEN-1:0] EBREAK_INST = 32'h0010_0073;

    // instruction field widths
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    // instruction field positions
    localparam int RD_BASE     = 7;
    localparam int FUNCT3_BASE = 12;
    localparam int RS1_BASE    = 15;
    localparam int RS2_BASE    = 20;
    localparam int FUNCT7_BASE = 25;

    // funct codes of the supported subset
    localparam logic [FUNCT3_W-1:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] FUNCT3_ADDI    = 3'b000;
    localparam logic [FUNCT3_W-1:0] FUNCT3_BNE     = 3'b001;
    localparam logic [FUNCT3_W-1:0] FUNCT3_JALR    = 3'b000;
    localparam logic [FUNCT7_W-1:0] FUNCT7_ADD     = 7'b000_0000;
    localparam logic [FUNCT7_W-1:0] FUNCT7_SUB     = 7'b010_0000;

    typedef enum logic [OPCODE_W-1:0] {
        OP_R      = 7'b011_0011,
        OP_IMM    = 7'b001_0011,
        OP_BRANCH = 7'b110_0011,
        OP_JAL    = 7'b110_1111,
        OP_JALR   = 7'b110_0111,
        OP_LUI    = 7'b011_0111,
        OP_AUIPC  = 7'b001_0111,
        OP_SYSTEM = 7'b111_0011
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG     = 2'd0, // rs1 op rs2
        SRC_IMM     = 2'd1, // rs1 op imm
        SRC_IMM_PC  = 2'd2, // pc op imm
        SRC_FOUR_PC = 2'd3  // pc op 4
    } alu_src_e;

    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_B = 2'd1,
        IMM_J = 2'd2,
        IMM_U = 2'd3
    } imm_op_e;

    typedef enum logic [1:0] {
        HALT_NONE    = 2'd0,
        HALT_EBREAK  = 2'd1,
        HALT_ILLEGAL = 2'd2
    } halt_e;

    typedef enum logic [1:0] {
        ST_FETCH = 2'd0,
        ST_EXEC  = 2'd1,
        ST_HALT  = 2'd2
    } fetch_state_e;

endpackage
